// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ulpi_line_state
FILELIST  := src.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP)
RUN_FLAGS := +verilator+error+limit+1000
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/link_init_fsm.sv
`timescale 1ns/1ps

module link_init_fsm
  import ulpi_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  line_status_t line_status_i,
  input  logic         ls_changed_i,
  input  logic         dir_i,
  input  logic         dir_q_i,
  input  logic         tick_i,
  input  logic         pulse_100us_i,
  input  logic         pulse_1ms_i,
  input  logic         pulse_3ms_i,
  input  logic         phy_done_i,
  output phy_cmd_t     phy_cmd_o,
  output logic         restart_100us_o,
  output logic         high_speed_o,
  output logic         usb_reset_o,
  output logic         idle_o,
  output logic [3:0]   phy_state_o
);

  logic [3:0] state_q;
  phy_cmd_t   cmd_q;
  // Set once the HS handshake has been attempted
  logic       hse_q;
  logic       hs_mode_q;
  logic       rst_q;
  logic       idle_q;
  logic       kj_valid_q;
  logic       kj_ended_q;
  logic [1:0] kj_count_q;
  logic [1:0] kj_count_next;
  logic       bus_turn;
  logic [1:0] ls;

  assign bus_turn      = dir_i || dir_q_i;
  assign ls            = line_status_i.line_state;
  assign kj_count_next = kj_count_q + 2'd1;

  assign restart_100us_o = (state_q == ST_FS_START) && phy_done_i && !bus_turn;

  // Mode and reset flags seen by the rest of the core
  always_ff @(posedge clock) begin
    if (reset) begin
      hs_mode_q <= 1'b0;
      rst_q     <= 1'b1;
      idle_q    <= 1'b0;
    end else begin
      idle_q <= hse_q && (state_q == ST_IDLE);
      if (state_q == ST_FS_START) begin
        hs_mode_q <= 1'b0;
      end else if (state_q == ST_IDLE && hse_q) begin
        hs_mode_q <= 1'b1;
      end
      if (state_q == ST_POWER_ON || state_q == ST_RESET) begin
        rst_q <= 1'b1;
      end else if (state_q == ST_IDLE) begin
        rst_q <= 1'b0;
      end
    end
  end

  // Host chirp train where each symbol counts as valid after one tick
  always_ff @(posedge clock) begin
    if (reset || state_q != ST_CHIRP_KJ) begin
      kj_valid_q <= 1'b0;
      kj_ended_q <= 1'b0;
      kj_count_q <= 2'd0;
    end else begin
      if (tick_i) begin
        kj_valid_q <= 1'b1;
      end else if (ls_changed_i) begin
        kj_valid_q <= 1'b0;
      end
      if (ls_changed_i && ls == LS_J) begin
        kj_count_q <= kj_count_next;
        if (kj_count_next == 2'd3) begin
          kj_ended_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= ST_POWER_ON;
      hse_q       <= 1'b0;
      cmd_q.write <= 1'b0;
      cmd_q.nopid <= 1'b0;
      cmd_q.stop  <= 1'b0;
    end else begin
      cmd_q.stop <= 1'b0;
      if (bus_turn) begin
        // Register write waits while the PHY owns the bus
        cmd_q.write <= 1'b0;
      end else begin
        case (state_q)
          ST_POWER_ON: begin
            if (phy_done_i) begin
              state_q     <= ST_FS_START;
              cmd_q.write <= 1'b0;
            end else begin
              {cmd_q.write, cmd_q.addr, cmd_q.data} <=
                {1'b1, REG_OTG_CTRL_ADDR, OTG_CTRL_DEFAULT};
            end
          end

          ST_FS_START: begin
            hse_q <= 1'b0;
            if (phy_done_i) begin
              state_q     <= ST_FS_LSSE0;
              cmd_q.write <= 1'b0;
            end else begin
              {cmd_q.write, cmd_q.addr, cmd_q.data} <= {1'b1, REG_FUNC_CTRL_ADDR, FUNC_FS};
            end
          end

          // SE0 from the host means a reset, which starts the chirp
          ST_FS_LSSE0: begin
            if (ls == LS_SE0) begin
              state_q <= ST_WAIT_SE0;
            end else if (pulse_100us_i) begin
              state_q <= ST_IDLE;
            end
          end

          ST_WAIT_SE0: begin
            if (ls_changed_i) begin
              state_q <= ST_FS_LSSE0;
            end else if (tick_i) begin
              state_q <= ST_CHIRP_K0;
              hse_q   <= 1'b1;
              {cmd_q.write, cmd_q.addr, cmd_q.data} <=
                {1'b1, REG_FUNC_CTRL_ADDR, FUNC_CHIRP};
            end
          end

          ST_CHIRP_K0: begin
            if (phy_done_i) begin
              state_q     <= ST_CHIRP_K1;
              cmd_q.write <= 1'b0;
              cmd_q.nopid <= 1'b1;
            end else begin
              {cmd_q.write, cmd_q.addr, cmd_q.data} <=
                {1'b1, REG_FUNC_CTRL_ADDR, FUNC_CHIRP};
            end
          end

          // Chirp K lasts until the 1 ms pulse
          ST_CHIRP_K1: begin
            if (pulse_1ms_i) begin
              state_q    <= ST_CHIRP_K2;
              cmd_q.stop <= 1'b1;
            end
            if (phy_done_i) begin
              cmd_q.nopid <= 1'b0;
            end
          end

          ST_CHIRP_K2: begin
            cmd_q.nopid <= 1'b0;
            state_q     <= ST_CHIRP_KJ;
          end

          ST_CHIRP_KJ: begin
            if (kj_ended_q && kj_valid_q) begin
              state_q <= ST_HS_START;
            end
          end

          ST_HS_START: begin
            if (phy_done_i) begin
              state_q     <= ST_IDLE;
              cmd_q.write <= 1'b0;
            end else begin
              {cmd_q.write, cmd_q.addr, cmd_q.data} <= {1'b1, REG_FUNC_CTRL_ADDR, FUNC_HS};
            end
          end

          ST_IDLE: begin
            if (pulse_3ms_i && ls == LS_SE0) begin
              state_q <= ST_RESET;
            end else if (pulse_3ms_i && ls == LS_J) begin
              state_q <= ST_SUSPEND;
            end
          end

          ST_SUSPEND: begin
            if (ls != LS_J) begin
              state_q <= ST_IDLE;
            end
          end

          ST_RESET: begin
            if (tick_i) begin
              state_q <= ST_FS_START;
            end
          end

          default: state_q <= ST_POWER_ON;
        endcase
      end
    end
  end

  assign phy_cmd_o    = cmd_q;
  assign high_speed_o = hs_mode_q;
  assign usb_reset_o  = rst_q;
  assign idle_o       = idle_q;
  assign phy_state_o  = state_q;

endmodule

// File: hw/ls_timer_stage.sv
`timescale 1ns/1ps

module ls_timer_stage #(
  parameter int RATIO = 3
) (
  input  logic clock,
  input  logic reset,
  input  logic restart_i,
  input  logic pulse_i,
  output logic pulse_o
);

  localparam int CW = $clog2(RATIO + 1);

  logic [CW-1:0] cnt_q;

  // Divide the input pulses, any line state change starts over
  always_ff @(posedge clock) begin
    if (reset || restart_i) begin
      cnt_q   <= '0;
      pulse_o <= 1'b0;
    end else if (pulse_i && cnt_q == CW'(RATIO - 1)) begin
      cnt_q   <= '0;
      pulse_o <= 1'b1;
    end else begin
      if (pulse_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
      pulse_o <= 1'b0;
    end
  end

endmodule

// File: hw/tick_prescaler.sv
`timescale 1ns/1ps

module tick_prescaler #(
  parameter int CLKS_PER_TICK   = 150,
  parameter int TICKS_PER_100US = 40
) (
  input  logic clock,
  input  logic reset,
  input  logic restart_100us_i,
  output logic tick_o,
  output logic pulse_100us_o
);

  localparam int CW = $clog2(CLKS_PER_TICK + 1);
  localparam int TW = $clog2(TICKS_PER_100US + 1);

  logic [CW-1:0] clk_cnt_q;
  logic [TW-1:0] tick_cnt_q;

  // Free-running 2.5 us tick
  always_ff @(posedge clock) begin
    if (reset) begin
      clk_cnt_q <= '0;
      tick_o    <= 1'b0;
    end else if (clk_cnt_q == CW'(CLKS_PER_TICK - 1)) begin
      clk_cnt_q <= '0;
      tick_o    <= 1'b1;
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
      tick_o    <= 1'b0;
    end
  end

  // 100 us window, restarted when FS start completes
  always_ff @(posedge clock) begin
    if (reset || restart_100us_i) begin
      tick_cnt_q    <= '0;
      pulse_100us_o <= 1'b0;
    end else if (tick_o && tick_cnt_q == TW'(TICKS_PER_100US - 1)) begin
      tick_cnt_q    <= '0;
      pulse_100us_o <= 1'b1;
    end else begin
      if (tick_o) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
      pulse_100us_o <= 1'b0;
    end
  end

endmodule

// File: hw/ulpi_line_state.sv
`timescale 1ns/1ps

module ulpi_line_state
  import ulpi_pkg::*;
#(
  parameter int CLKS_PER_TICK   = 150,
  parameter int TICKS_PER_100US = 40,
  parameter int TICKS_PER_MS    = 400
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         dir_i,
  input  logic         nxt_i,
  input  logic [7:0]   data_i,
  input  logic         sof_i,
  input  logic         phy_done_i,
  output line_status_t line_status_o,
  output logic         ls_changed_o,
  output logic         rx_cmd_o,
  output phy_cmd_t     phy_cmd_o,
  output logic         high_speed_o,
  output logic         usb_reset_o,
  output logic         idle_o,
  output logic [3:0]   phy_state_o,
  output logic         tick_o,
  output logic         pulse_1ms_o
);

  // Stage ratios give 1 ms, 3 ms and 21 ms of constant line state
  localparam int STAGE_RATIO [3] = '{TICKS_PER_MS, 3, 7};

  line_status_t line_status;
  logic         ls_changed;
  logic         dir_q;
  logic         tick;
  logic         pulse_100us;
  logic         restart_100us;
  logic [2:0]   stage_in;
  logic [2:0]   stage_pulse;

  ulpi_rx_sampler i_ulpi_rx_sampler (
    .clock         (clock),
    .reset         (reset),
    .dir_i         (dir_i),
    .nxt_i         (nxt_i),
    .data_i        (data_i),
    .sof_i         (sof_i),
    .line_status_o (line_status),
    .ls_changed_o  (ls_changed),
    .rx_cmd_o      (rx_cmd_o),
    .dir_q_o       (dir_q)
  );

  tick_prescaler #(
    .CLKS_PER_TICK   (CLKS_PER_TICK),
    .TICKS_PER_100US (TICKS_PER_100US)
  ) i_tick_prescaler (
    .clock           (clock),
    .reset           (reset),
    .restart_100us_i (restart_100us),
    .tick_o          (tick),
    .pulse_100us_o   (pulse_100us)
  );

  // Each stage is clocked by the pulse of the one before
  assign stage_in = {stage_pulse[1:0], tick};

  for (genvar g = 0; g < 3; g++) begin : g_stage
    ls_timer_stage #(
      .RATIO (STAGE_RATIO[g])
    ) i_ls_timer_stage (
      .clock     (clock),
      .reset     (reset),
      .restart_i (ls_changed),
      .pulse_i   (stage_in[g]),
      .pulse_o   (stage_pulse[g])
    );
  end

  link_init_fsm i_link_init_fsm (
    .clock           (clock),
    .reset           (reset),
    .line_status_i   (line_status),
    .ls_changed_i    (ls_changed),
    .dir_i           (dir_i),
    .dir_q_i         (dir_q),
    .tick_i          (tick),
    .pulse_100us_i   (pulse_100us),
    .pulse_1ms_i     (stage_pulse[0]),
    .pulse_3ms_i     (stage_pulse[1]),
    .phy_done_i      (phy_done_i),
    .phy_cmd_o       (phy_cmd_o),
    .restart_100us_o (restart_100us),
    .high_speed_o    (high_speed_o),
    .usb_reset_o     (usb_reset_o),
    .idle_o          (idle_o),
    .phy_state_o     (phy_state_o)
  );

  assign line_status_o = line_status;
  assign ls_changed_o  = ls_changed;
  assign tick_o        = tick;
  assign pulse_1ms_o   = stage_pulse[0];

endmodule

// File: hw/ulpi_pkg.sv
package ulpi_pkg;

  // UTMI+ style line status carried in the low bits of an RX CMD
  typedef struct packed {
    logic [1:0] rx_event;
    logic [1:0] vbus_state;
    logic [1:0] line_state;
  } line_status_t;

  typedef struct packed {
    logic [1:0]   id_alt;
    line_status_t status;
  } rx_cmd_t;

  // Registered ULPI data word, seen as an RX CMD or as a raw byte
  typedef union packed {
    rx_cmd_t    cmd;
    logic [7:0] raw;
  } ulpi_byte_u;

  // Request towards the ULPI transmit engine
  typedef struct packed {
    logic       write;
    logic       nopid;
    logic       stop;
    logic [7:0] addr;
    logic [7:0] data;
  } phy_cmd_t;

  localparam logic [1:0] LS_SE0 = 2'd0;
  localparam logic [1:0] LS_J   = 2'd1;
  localparam logic [1:0] LS_K   = 2'd2;

  // Code 11 was the resume state and stays unused
  localparam logic [3:0] ST_POWER_ON = 4'd0;
  localparam logic [3:0] ST_FS_START = 4'd1;
  localparam logic [3:0] ST_FS_LSSE0 = 4'd2;
  localparam logic [3:0] ST_WAIT_SE0 = 4'd3;
  localparam logic [3:0] ST_CHIRP_K0 = 4'd4;
  localparam logic [3:0] ST_CHIRP_K1 = 4'd5;
  localparam logic [3:0] ST_CHIRP_K2 = 4'd6;
  localparam logic [3:0] ST_CHIRP_KJ = 4'd7;
  localparam logic [3:0] ST_HS_START = 4'd8;
  localparam logic [3:0] ST_IDLE     = 4'd9;
  localparam logic [3:0] ST_SUSPEND  = 4'd10;
  localparam logic [3:0] ST_RESET    = 4'd12;

  localparam logic [7:0] REG_OTG_CTRL_ADDR  = 8'h8A;
  localparam logic [7:0] OTG_CTRL_DEFAULT   = 8'h00;
  localparam logic [7:0] REG_FUNC_CTRL_ADDR = 8'h84;
  localparam logic [7:0] FUNC_FS            = 8'h45;
  localparam logic [7:0] FUNC_CHIRP         = 8'h54;
  localparam logic [7:0] FUNC_HS            = 8'h40;

endpackage

// File: hw/ulpi_rx_sampler.sv
`timescale 1ns/1ps

module ulpi_rx_sampler
  import ulpi_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         dir_i,
  input  logic         nxt_i,
  input  logic [7:0]   data_i,
  input  logic         sof_i,
  output line_status_t line_status_o,
  output logic         ls_changed_o,
  output logic         rx_cmd_o,
  output logic         dir_q_o
);

  logic         dir_q;
  ulpi_byte_u   data_q;
  logic         rx_cmd_q;
  logic         changed_q;
  logic         ls_changed_q;
  line_status_t status_q;

  // Pin registers, the data byte carries no reset
  always_ff @(posedge clock) begin
    data_q.raw <= data_i;
  end

  // RX CMD needs dir high for the turnaround cycle and this one, with nxt low
  always_ff @(posedge clock) begin
    if (reset) begin
      dir_q        <= 1'b0;
      rx_cmd_q     <= 1'b0;
      changed_q    <= 1'b0;
      ls_changed_q <= 1'b0;
    end else begin
      dir_q        <= dir_i;
      rx_cmd_q     <= dir_q && dir_i && !nxt_i;
      changed_q    <= rx_cmd_q &&
                      (data_q.cmd.status.line_state != status_q.line_state);
      ls_changed_q <= changed_q || sof_i;
    end
  end

  // Held line status, K until the PHY reports otherwise
  always_ff @(posedge clock) begin
    if (reset) begin
      status_q.rx_event   <= 2'b00;
      status_q.vbus_state <= 2'b00;
      status_q.line_state <= LS_K;
    end else if (rx_cmd_q) begin
      status_q <= data_q.cmd.status;
    end
  end

  assign line_status_o = status_q;
  assign ls_changed_o  = ls_changed_q;
  assign rx_cmd_o      = rx_cmd_q;
  assign dir_q_o       = dir_q;

endmodule

// File: src.f
hw/ulpi_pkg.sv
hw/ulpi_rx_sampler.sv
hw/tick_prescaler.sv
hw/ls_timer_stage.sv
hw/link_init_fsm.sv
hw/ulpi_line_state.sv
testbench/ulpi_line_state_checker.sv
testbench/tb_ulpi_line_state.sv

// File: testbench/tb_ulpi_line_state.sv
`timescale 1ns/1ps

module tb_ulpi_line_state;
  import ulpi_pkg::*;

  localparam int CLKS_PER_TICK   = 4;
  localparam int TICKS_PER_100US = 10;
  localparam int TICKS_PER_MS    = 8;

  logic         clock;
  logic         reset;
  logic         dir_i;
  logic         nxt_i;
  logic [7:0]   data_i;
  logic         sof_i;
  logic         phy_done_i;
  line_status_t line_status_o;
  logic         ls_changed_o;
  logic         rx_cmd_o;
  phy_cmd_t     phy_cmd_o;
  logic         high_speed_o;
  logic         usb_reset_o;
  logic         idle_o;
  logic [3:0]   phy_state_o;
  logic         tick_o;
  logic         pulse_1ms_o;

  integer      seed = 32'h13f9d853;
  int          errors = 0;
  int          stop_count = 0;
  logic [15:0] write_log [$];
  // Line status as the PHY last reported it
  logic [5:0]  exp_status;

  ulpi_line_state #(
    .CLKS_PER_TICK   (CLKS_PER_TICK),
    .TICKS_PER_100US (TICKS_PER_100US),
    .TICKS_PER_MS    (TICKS_PER_MS)
  ) i_ulpi_line_state (.*);

  initial clock = 1'b0;
  always #5 clock = ~clock;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic skip_cycles(input int n);
    repeat (n) @(posedge clock);
    #1;
  endtask

  task automatic wait_for_state(input logic [3:0] target, input int limit);
    int cycles;
    cycles = 0;
    while (phy_state_o != target && cycles < limit) begin
      skip_cycles(1);
      cycles++;
    end
    if (phy_state_o != target) begin
      errors++;
      $display("Timeout at %0t: link FSM never reached state %0d", $time, target);
    end
  endtask

  task automatic check_write(input int idx, input logic [15:0] exp);
    if (idx >= write_log.size()) begin
      errors++;
      $display("Register write number %0d was never completed", idx);
    end else begin
      check_eq($sformatf("write_log[%0d]", idx), write_log[idx], exp);
    end
  endtask

  // Selects tick_o or pulse_1ms_o
  function automatic logic timer_pulse_level(input int sel);
    return (sel == 0) ? tick_o : pulse_1ms_o;
  endfunction

  // Cycles from one pulse of a timer output to the next
  task automatic compare_pulse_gap(input string name, input int sel, input int exp_gap);
    int cycles;
    cycles = 0;
    while (!timer_pulse_level(sel) && cycles < 4 * exp_gap) begin
      skip_cycles(1);
      cycles++;
    end
    if (!timer_pulse_level(sel)) begin
      errors++;
      $display("Timeout at %0t: %s never pulsed", $time, name);
    end else begin
      cycles = 0;
      skip_cycles(1);
      while (!timer_pulse_level(sel) && cycles < 4 * exp_gap) begin
        skip_cycles(1);
        cycles++;
      end
      if (!timer_pulse_level(sel)) begin
        errors++;
        $display("Timeout at %0t: %s pulsed only once", $time, name);
      end else begin
        check_eq({name, " period"}, cycles + 1, exp_gap);
      end
    end
  endtask

  // Turnaround cycle, then the RX CMD byte, then the bus goes back
  task automatic send_rx_cmd(input logic [7:0] cmd_byte, input logic nxt);
    dir_i  = 1'b1;
    nxt_i  = 1'b0;
    data_i = 8'h00;
    skip_cycles(1);
    nxt_i  = nxt;
    data_i = cmd_byte;
    skip_cycles(1);
    dir_i  = 1'b0;
    nxt_i  = 1'b0;
    data_i = 8'h00;
  endtask

  task automatic decode_rx(input logic [7:0] cmd_byte, input logic nxt);
    logic [5:0] next_status;
    logic       changed;
    next_status = nxt ? exp_status : cmd_byte[5:0];
    changed     = (next_status[1:0] != exp_status[1:0]);
    send_rx_cmd(cmd_byte, nxt);
    check_eq("rx_cmd_o", rx_cmd_o, !nxt);
    skip_cycles(1);
    check_eq("line_status_o", line_status_o, next_status);
    skip_cycles(1);
    check_eq("ls_changed_o", ls_changed_o, changed);
    exp_status = next_status;
  endtask

  // PHY side of the transmit engine acknowledging a pending request
  always begin : phy_model
    int delay;
    skip_cycles(1);
    if (phy_cmd_o.write || phy_cmd_o.nopid) begin
      delay = 1 + ($unsigned($random(seed)) % 8);
      skip_cycles(delay);
      if (phy_cmd_o.write || phy_cmd_o.nopid) begin
        phy_done_i = 1'b1;
        skip_cycles(1);
        phy_done_i = 1'b0;
      end
    end
  end

  // Writes taken by the FSM and stop pulses
  always @(posedge clock) begin
    if (!reset && phy_cmd_o.write && phy_done_i && !dir_i) begin
      write_log.push_back({phy_cmd_o.addr, phy_cmd_o.data});
    end
    if (!reset && phy_cmd_o.stop) begin
      stop_count++;
    end
  end

  initial begin : main
    int cycles;
    int fails;
    reset      = 1'b1;
    dir_i      = 1'b0;
    nxt_i      = 1'b0;
    data_i     = 8'h00;
    sof_i      = 1'b0;
    phy_done_i = 1'b0;
    exp_status = 6'h02;
    skip_cycles(4);
    reset = 1'b0;
    check_eq("usb_reset_o", usb_reset_o, 1);
    check_eq("phy_cmd_o.write", phy_cmd_o.write, 0);
    check_eq("line_status_o", line_status_o, exp_status);
    check_eq("phy_state_o", phy_state_o, ST_POWER_ON);

    // Raise dir while the first write is pending
    cycles = 0;
    while (!phy_cmd_o.write && cycles < 20) begin
      skip_cycles(1);
      cycles++;
    end
    if (!phy_cmd_o.write) begin
      errors++;
      $display("Timeout at %0t: no register write after reset", $time);
    end
    decode_rx(8'h0D, 1'b0);
    decode_rx(8'h09, 1'b0);
    decode_rx(8'h02, 1'b1);
    wait_for_state(ST_FS_LSSE0, 200);
    check_write(0, {REG_OTG_CTRL_ADDR, OTG_CTRL_DEFAULT});
    check_write(1, {REG_FUNC_CTRL_ADDR, FUNC_FS});

    // Full speed when the host sends no SE0
    wait_for_state(ST_IDLE, 100);
    for (int i = 0; i < 8; i++) begin
      skip_cycles(1);
      check_eq("idle_o", idle_o, 0);
    end
    check_eq("high_speed_o", high_speed_o, 0);
    check_eq("usb_reset_o", usb_reset_o, 0);

    // SOF alone gives a change pulse and restarts the timer chain
    sof_i = 1'b1;
    skip_cycles(1);
    check_eq("ls_changed_o", ls_changed_o, 1);
    sof_i = 1'b0;
    skip_cycles(1);
    check_eq("ls_changed_o", ls_changed_o, 0);
    compare_pulse_gap("tick_o", 0, CLKS_PER_TICK);
    compare_pulse_gap("pulse_1ms_o", 1, CLKS_PER_TICK * TICKS_PER_MS);

    // Bus reset followed by SE0 long enough for the chirp
    decode_rx(8'h0C, 1'b0);
    wait_for_state(ST_RESET, 300);
    wait_for_state(ST_CHIRP_K1, 300);
    check_eq("phy_cmd_o.nopid", phy_cmd_o.nopid, 1);
    check_write(2, {REG_FUNC_CTRL_ADDR, FUNC_FS});
    check_write(3, {REG_FUNC_CTRL_ADDR, FUNC_CHIRP});
    wait_for_state(ST_CHIRP_KJ, 100);
    check_eq("stop_count", stop_count, 1);
    for (int i = 0; i < 3; i++) begin
      decode_rx(8'h0E, 1'b0);
      skip_cycles(4);
      decode_rx(8'h0D, 1'b0);
      skip_cycles(4);
    end
    wait_for_state(ST_IDLE, 100);
    skip_cycles(1);
    check_eq("idle_o", idle_o, 1);
    check_eq("high_speed_o", high_speed_o, 1);
    check_eq("usb_reset_o", usb_reset_o, 0);
    check_write(4, {REG_FUNC_CTRL_ADDR, FUNC_HS});

    // J held leads to suspend and K wakes it
    wait_for_state(ST_SUSPEND, 200);
    decode_rx(8'h0E, 1'b0);
    wait_for_state(ST_IDLE, 20);
    decode_rx(8'h0C, 1'b0);
    wait_for_state(ST_RESET, 200);
    wait_for_state(ST_FS_START, 20);
    skip_cycles(1);
    check_eq("high_speed_o", high_speed_o, 0);
    check_eq("usb_reset_o", usb_reset_o, 1);

    fails = i_ulpi_line_state.i_ulpi_line_state_checker.fail_count;
    $display("Error counts: %0d testbench checks, %0d assertion failures", errors, fails);
    if (errors == 0 && fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/ulpi_line_state_checker.sv
`timescale 1ns/1ps

module ulpi_line_state_checker
  import ulpi_pkg::*;
(
  input logic     clock,
  input logic     reset,
  input logic     dir_i,
  input phy_cmd_t phy_cmd_i,
  input logic     high_speed_i,
  input logic     idle_i
);

  int          fail_count = 0;
  logic [15:0] write_pair;
  logic        pair_ok;

  assign write_pair = {phy_cmd_i.addr, phy_cmd_i.data};
  assign pair_ok    = (write_pair == {REG_OTG_CTRL_ADDR, OTG_CTRL_DEFAULT}) ||
                      (write_pair == {REG_FUNC_CTRL_ADDR, FUNC_FS}) ||
                      (write_pair == {REG_FUNC_CTRL_ADDR, FUNC_CHIRP}) ||
                      (write_pair == {REG_FUNC_CTRL_ADDR, FUNC_HS});

  // Only the four start-up register writes may be requested
  a_write_pair: assert property (@(posedge clock) disable iff (reset)
    phy_cmd_i.write |-> pair_ok)
  else begin
    $error("register write request with unexpected address or data %h", write_pair);
    fail_count++;
  end

  // No write may follow a cycle with dir high
  a_turnaround: assert property (@(posedge clock) disable iff (reset)
    $past(dir_i) |-> !phy_cmd_i.write)
  else begin
    $error("register write requested right after dir was high");
    fail_count++;
  end

  a_idle_hs: assert property (@(posedge clock) disable iff (reset)
    idle_i |-> high_speed_i)
  else begin
    $error("idle flag set without high speed");
    fail_count++;
  end

endmodule

bind ulpi_line_state ulpi_line_state_checker i_ulpi_line_state_checker (
  .clock        (clock),
  .reset        (reset),
  .dir_i        (dir_i),
  .phy_cmd_i    (phy_cmd_o),
  .high_speed_i (high_speed_o),
  .idle_i       (idle_o)
);
